// File: src/battle_macros.svh
`ifndef BATTLE_MACROS_SVH
`define BATTLE_MACROS_SVH

// Board geometry, one side of the square grid
`define BOARD_N 5

// Upper limit of the ship count chosen by the player
`define MAX_SHIPS 5

// Cycles the machine waits before it starts looking for a target
`define PC_THINK_CYCLES 8

// Events the receiver can take before it returns a credit
`define EVT_CREDITS 4

// Start value of the coordinate LFSR, must not be zero
`define LFSR_SEED 16'hACE1

`endif

// File: src/battle_game_pkg.sv
`default_nettype none

package battle_game_pkg;

	// Game sequence, one-hot not needed at this size
	typedef enum logic [2:0] {
		DECIDE,       // Waiting for the ship count
		PLACE,        // Player places ships with the cursor
		SETUP,        // Machine places ships from the LFSR
		PLAYER_TURN,
		PC_TURN,
		VICTORY,      // Machine fleet gone
		DEFEAT        // Player fleet gone
	} game_state_e;

	// Contents of one board cell
	typedef enum logic [1:0] {
		EMPTY,
		SHIP,         // Ship not yet hit
		MISS,         // Shot on water
		HIT           // Shot on a ship
	} cell_e;

	// Grid position, row is the vertical index
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} coord_t;

	// Outcome of one shot as it is reported
	typedef enum logic {
		MISS_R,
		HIT_R
	} shot_result_e;

endpackage

`default_nettype wire

// File: src/battle_io_pkg.sv
`default_nettype none

package battle_io_pkg;

	// Clean single-cycle button pulses
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic confirm_amount;
		logic confirm_place;
		logic fire;
	} buttons_t;

	// One shot report on the event channel
	typedef struct packed {
		logic                           shooter;    // 1 when the machine fired
		battle_game_pkg::coord_t        coord;
		battle_game_pkg::shot_result_e  result;
		logic                           game_over;  // Last ship of a fleet sunk
	} shot_evt_t;

	// Count to active-high segments, gfedcba
	function automatic logic [6:0] seg7(input logic [2:0] count);
		case (count)
			3'd0:    return 7'h3F;
			3'd1:    return 7'h06;
			3'd2:    return 7'h5B;
			3'd3:    return 7'h4F;
			3'd4:    return 7'h66;
			3'd5:    return 7'h6D;
			default: return 7'h40;  // Dash, count out of range
		endcase
	endfunction

endpackage

`default_nettype wire

// File: src/game_fsm.sv
`default_nettype none

`include "battle_macros.svh"

module game_fsm (
	input  wire                              clk,
	input  wire                              i_rst_n,
	input  wire battle_io_pkg::buttons_t     i_btn,
	input  wire [2:0]                        i_ship_count,
	input  wire                              i_can_send,        // Event channel has a credit
	input  wire                              i_timer_done,
	input  wire [2:0]                        i_player_left,
	input  wire [2:0]                        i_pc_left,
	input  wire                              i_pc_place_ok,     // Cell on machine board free and on grid
	input  wire                              i_pc_shot_ok,      // Target cell of this turn unshot
	input  wire                              i_player_place_ok, // Cell on player board free
	output battle_game_pkg::game_state_e     o_state,
	output logic [2:0]                       o_ship_target,
	output logic                             o_place_player,
	output logic                             o_place_pc,
	output logic                             o_fire_pc_board,
	output logic                             o_fire_player_board,
	output logic                             o_draw,            // Advance the LFSR
	output logic                             o_timer_start,
	output logic                             o_evt_send,
	output logic                             o_error
);

	battle_game_pkg::game_state_e state_nx;
	logic [2:0] tally;      // Ships placed in the current phase
	logic [2:0] amount;     // Clamped count from the switches
	logic       last_ship;
	logic       fire_pend;  // Player shot waiting for a credit
	logic       player_try;
	logic       pc_hunt;    // Think delay over, machine looks for a target
	logic       err_nx;
	logic       pend_nx;

	always_comb begin
		if (i_ship_count == 3'd0)
			amount = 3'd1;
		else if (i_ship_count > 3'(`MAX_SHIPS))
			amount = 3'(`MAX_SHIPS);
		else
			amount = i_ship_count;
	end

	assign last_ship  = (tally + 3'd1 == o_ship_target);
	assign player_try = i_btn.fire || fire_pend;

	always_comb begin
		state_nx            = o_state;
		o_place_player      = 1'b0;
		o_place_pc          = 1'b0;
		o_fire_pc_board     = 1'b0;
		o_fire_player_board = 1'b0;
		o_draw              = 1'b0;
		o_timer_start       = 1'b0;
		o_evt_send          = 1'b0;
		err_nx              = 1'b0;
		pend_nx             = 1'b0;
		case (o_state)
			battle_game_pkg::DECIDE: begin
				if (i_btn.confirm_amount)
					state_nx = battle_game_pkg::PLACE;
			end
			battle_game_pkg::PLACE: begin
				if (i_btn.confirm_place) begin
					o_place_player = i_player_place_ok;
					err_nx         = !i_player_place_ok;  // Cell already taken
					if (i_player_place_ok && last_ship)
						state_nx = battle_game_pkg::SETUP;
				end
			end
			battle_game_pkg::SETUP: begin
				o_draw     = 1'b1;  // One candidate per cycle, bad ones dropped
				o_place_pc = i_pc_place_ok;
				if (i_pc_place_ok && last_ship)
					state_nx = battle_game_pkg::PLAYER_TURN;
			end
			battle_game_pkg::PLAYER_TURN: begin
				err_nx  = i_btn.fire && !i_pc_shot_ok;  // Repeat shot
				pend_nx = player_try && i_pc_shot_ok && !i_can_send;
				if (player_try && i_pc_shot_ok && i_can_send) begin
					o_fire_pc_board = 1'b1;
					o_evt_send      = 1'b1;
					// Occupied cell means a hit, last one ends the game
					if (!i_pc_place_ok && i_pc_left == 3'd1) begin
						state_nx = battle_game_pkg::VICTORY;
					end else begin
						state_nx      = battle_game_pkg::PC_TURN;
						o_timer_start = 1'b1;
					end
				end
			end
			battle_game_pkg::PC_TURN: begin
				if (pc_hunt) begin
					if (i_pc_shot_ok && i_can_send) begin
						o_fire_player_board = 1'b1;
						o_evt_send          = 1'b1;
						o_draw              = 1'b1;
						if (!i_player_place_ok && i_player_left == 3'd1)
							state_nx = battle_game_pkg::DEFEAT;
						else
							state_nx = battle_game_pkg::PLAYER_TURN;
					end else if (!i_pc_shot_ok) begin
						o_draw = 1'b1;  // Already shot or off grid, try next
					end
				end
			end
			default: ;  // End states hold until reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_state       <= battle_game_pkg::DECIDE;
			o_ship_target <= 3'd1;
			tally         <= 3'd0;
			fire_pend     <= 1'b0;
			pc_hunt       <= 1'b0;
			o_error       <= 1'b0;
		end else begin
			o_state   <= state_nx;
			o_error   <= err_nx;
			fire_pend <= pend_nx;
			if (o_state == battle_game_pkg::DECIDE && i_btn.confirm_amount)
				o_ship_target <= amount;
			if (o_place_player || o_place_pc)
				tally <= last_ship ? 3'd0 : tally + 3'd1;  // Restart for the machine fleet
			if (i_timer_done)
				pc_hunt <= 1'b1;
			else if (o_fire_player_board)
				pc_hunt <= 1'b0;
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_state inside {battle_game_pkg::DECIDE, battle_game_pkg::PLACE,
			battle_game_pkg::SETUP, battle_game_pkg::PLAYER_TURN,
			battle_game_pkg::PC_TURN, battle_game_pkg::VICTORY, battle_game_pkg::DEFEAT});

endmodule

`default_nettype wire

// File: src/turn_timer.sv
`default_nettype none

`include "battle_macros.svh"

module turn_timer (
	input  wire  clk,
	input  wire  i_rst_n,
	input  wire  i_start,
	output logic o_done   // Pulse when the delay runs out
);

	localparam int TW = $clog2(`PC_THINK_CYCLES + 1);

	logic [TW-1:0] count;  // Zero means idle

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			count  <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				count <= TW'(`PC_THINK_CYCLES);  // Restart even if busy
			end else if (count != '0) begin
				count  <= count - 1'b1;
				o_done <= (count == TW'(1));
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cursor_ctrl.sv
`default_nettype none

`include "battle_macros.svh"

module cursor_ctrl (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire battle_io_pkg::buttons_t i_btn,
	input  wire                          i_enable,  // Only in placement and player turn
	output battle_game_pkg::coord_t      o_cursor
);

	localparam logic [2:0] EDGE = 3'(`BOARD_N - 1);  // Last row and col

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_cursor <= '0;  // Top left corner
		end else if (i_enable) begin
			// One step per cycle, up wins over down over left over right
			if (i_btn.up) begin
				if (o_cursor.row != 3'd0)
					o_cursor.row <= o_cursor.row - 3'd1;
			end else if (i_btn.down) begin
				if (o_cursor.row != EDGE)
					o_cursor.row <= o_cursor.row + 3'd1;
			end else if (i_btn.left) begin
				if (o_cursor.col != 3'd0)
					o_cursor.col <= o_cursor.col - 3'd1;
			end else if (i_btn.right) begin
				if (o_cursor.col != EDGE)
					o_cursor.col <= o_cursor.col + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/coord_lfsr.sv
`default_nettype none

`include "battle_macros.svh"

module coord_lfsr (
	input  wire                      clk,
	input  wire                      i_rst_n,
	input  wire                      i_advance,  // One step per draw
	output battle_game_pkg::coord_t  o_coord,
	output logic                     o_in_range
);

	// Galois feedback for x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] TAPS = 16'hB400;

	logic [15:0] lfsr_q;
	logic [15:0] lfsr_nx;

	assign lfsr_nx = lfsr_q[0] ? ((lfsr_q >> 1) ^ TAPS) : (lfsr_q >> 1);

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			lfsr_q <= `LFSR_SEED;
		else if (i_advance)
			lfsr_q <= lfsr_nx;  // Holds between draws
	end

	// Low bits give the candidate cell
	assign o_coord.row = lfsr_q[2:0];
	assign o_coord.col = lfsr_q[5:3];

	// Rows and cols 5 to 7 fall off the grid
	assign o_in_range = (o_coord.row < 3'(`BOARD_N)) && (o_coord.col < 3'(`BOARD_N));

endmodule

`default_nettype wire

// File: src/ship_board.sv
`default_nettype none

`include "battle_macros.svh"

module ship_board (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            i_place,
	input  wire                            i_fire,
	input  wire battle_game_pkg::coord_t   i_coord,
	output logic                           o_cell_free,    // EMPTY
	output logic                           o_cell_unshot,  // EMPTY or SHIP
	output battle_game_pkg::shot_result_e  o_result,       // Outcome if fired now
	output logic [2:0]                     o_ships_left,
	output logic [6:0]                     o_seg
);

	battle_game_pkg::cell_e cells [`BOARD_N][`BOARD_N];
	battle_game_pkg::cell_e cell_rd;
	logic                   on_grid;

	assign on_grid = (i_coord.row < 3'(`BOARD_N)) && (i_coord.col < 3'(`BOARD_N));

	// Off-grid reads look like a used cell so nothing acts on them
	assign cell_rd = on_grid ? cells[i_coord.row][i_coord.col] : battle_game_pkg::MISS;

	assign o_cell_free   = (cell_rd == battle_game_pkg::EMPTY);
	assign o_cell_unshot = (cell_rd == battle_game_pkg::EMPTY) || (cell_rd == battle_game_pkg::SHIP);
	assign o_result      = (cell_rd == battle_game_pkg::SHIP) ? battle_game_pkg::HIT_R
	                                                         : battle_game_pkg::MISS_R;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int r = 0; r < `BOARD_N; r++) begin
				for (int c = 0; c < `BOARD_N; c++)
					cells[r][c] <= battle_game_pkg::EMPTY;
			end
			o_ships_left <= 3'd0;
		end else if (on_grid) begin
			if (i_place) begin
				cells[i_coord.row][i_coord.col] <= battle_game_pkg::SHIP;
				o_ships_left <= o_ships_left + 3'd1;
			end else if (i_fire) begin
				if (cell_rd == battle_game_pkg::SHIP) begin
					cells[i_coord.row][i_coord.col] <= battle_game_pkg::HIT;
					o_ships_left <= o_ships_left - 3'd1;  // One ship per cell
				end else begin
					cells[i_coord.row][i_coord.col] <= battle_game_pkg::MISS;
				end
			end
		end
	end

	assign o_seg = battle_io_pkg::seg7(o_ships_left);

	// A board is either being set up or being shot at
	a_place_fire_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_place && i_fire));

endmodule

`default_nettype wire

// File: src/event_link.sv
`default_nettype none

`include "battle_macros.svh"

module event_link (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire                           i_send,
	input  wire battle_io_pkg::shot_evt_t i_evt,
	input  wire                           i_credit,     // Receiver frees one slot
	output logic                          o_can_send,
	output battle_io_pkg::shot_evt_t      o_evt,
	output logic                          o_evt_valid
);

	localparam int CW = $clog2(`EVT_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          spend;

	assign o_can_send = (credits != '0);
	assign spend      = i_send && o_can_send;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			credits     <= CW'(`EVT_CREDITS);
			o_evt_valid <= 1'b0;
		end else begin
			o_evt_valid <= spend;
			credits     <= credits - CW'(spend) + CW'(i_credit);  // Both in one cycle cancel
		end
	end

	// Report payload, qualified by o_evt_valid
	always_ff @(posedge clk) begin
		if (spend)
			o_evt <= i_evt;
	end

	// Receiver never returns more than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
		credits <= CW'(`EVT_CREDITS));

	// The FSM holds its shot while the channel is out of credits
	a_send_has_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_send |-> o_can_send);

endmodule

`default_nettype wire

// File: src/battleship_top.sv
`default_nettype none

`include "battle_macros.svh"

module battleship_top (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire battle_io_pkg::buttons_t  i_btn,
	input  wire [2:0]                     i_ship_count,
	input  wire                           i_evt_credit,
	output battle_game_pkg::game_state_e  o_state,
	output battle_game_pkg::coord_t       o_cursor,
	output logic                          o_placement_error,
	output battle_io_pkg::shot_evt_t      o_evt,
	output logic                          o_evt_valid,
	output logic [6:0]                    o_seg_player,
	output logic [6:0]                    o_seg_pc
);

	battle_game_pkg::coord_t       lfsr_coord, board_coord;
	battle_game_pkg::shot_result_e player_result, pc_result, shot_result;
	battle_io_pkg::shot_evt_t      shot_evt;
	logic [2:0] ship_target, player_left, pc_left, target_left;
	logic lfsr_in_range, use_cursor, coord_ok, pc_turn;
	logic player_free, player_unshot, pc_free, pc_unshot;
	logic pc_place_ok, shot_ok, can_send, timer_done;
	logic place_player, place_pc, fire_pc_board, fire_player_board;
	logic draw, timer_start, evt_send;

	// Player drives the boards with the cursor, the machine with the LFSR
	assign use_cursor  = (o_state == battle_game_pkg::PLACE) ||
	                     (o_state == battle_game_pkg::PLAYER_TURN);
	assign pc_turn     = (o_state == battle_game_pkg::PC_TURN);
	assign board_coord = use_cursor ? o_cursor : lfsr_coord;
	assign coord_ok    = use_cursor || lfsr_in_range;
	assign pc_place_ok = coord_ok && pc_free;
	assign shot_ok     = coord_ok && (pc_turn ? player_unshot : pc_unshot);  // Board under fire
	assign shot_result = pc_turn ? player_result : pc_result;
	assign target_left = pc_turn ? player_left : pc_left;

	always_comb begin
		shot_evt.shooter   = pc_turn;
		shot_evt.coord     = board_coord;
		shot_evt.result    = shot_result;
		shot_evt.game_over = (shot_result == battle_game_pkg::HIT_R) && (target_left == 3'd1);
	end

	game_fsm fsm_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_btn(i_btn), .i_ship_count(i_ship_count),
		.i_can_send(can_send), .i_timer_done(timer_done),
		.i_player_left(player_left), .i_pc_left(pc_left),
		.i_pc_place_ok(pc_place_ok), .i_pc_shot_ok(shot_ok),
		.i_player_place_ok(player_free),
		.o_state(o_state), .o_ship_target(ship_target),
		.o_place_player(place_player), .o_place_pc(place_pc),
		.o_fire_pc_board(fire_pc_board), .o_fire_player_board(fire_player_board),
		.o_draw(draw), .o_timer_start(timer_start), .o_evt_send(evt_send),
		.o_error(o_placement_error)
	);

	turn_timer timer_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_start(timer_start), .o_done(timer_done)
	);

	cursor_ctrl cursor_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_btn(i_btn), .i_enable(use_cursor),
		.o_cursor(o_cursor)
	);

	coord_lfsr lfsr_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_advance(draw),
		.o_coord(lfsr_coord), .o_in_range(lfsr_in_range)
	);

	ship_board player_board (
		.clk(clk), .i_rst_n(i_rst_n), .i_place(place_player), .i_fire(fire_player_board),
		.i_coord(board_coord), .o_cell_free(player_free), .o_cell_unshot(player_unshot),
		.o_result(player_result), .o_ships_left(player_left), .o_seg(o_seg_player)
	);

	ship_board pc_board (
		.clk(clk), .i_rst_n(i_rst_n), .i_place(place_pc), .i_fire(fire_pc_board),
		.i_coord(board_coord), .o_cell_free(pc_free), .o_cell_unshot(pc_unshot),
		.o_result(pc_result), .o_ships_left(pc_left), .o_seg(o_seg_pc)
	);

	event_link link_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_send(evt_send), .i_evt(shot_evt),
		.i_credit(i_evt_credit), .o_can_send(can_send),
		.o_evt(o_evt), .o_evt_valid(o_evt_valid)
	);

	// Neither fleet grows past the count latched at the start
	a_fleet_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
		(player_left <= ship_target) && (pc_left <= ship_target));

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic o_clk
);

	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period, starts low
	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

// File: tb/battleship_checker.sv
`default_nettype none

`include "battle_macros.svh"

module battleship_checker (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire battle_io_pkg::buttons_t  i_btn,
	input  wire [2:0]                     i_ship_count,
	input  wire                           i_evt_credit,
	input  wire battle_game_pkg::game_state_e i_state,
	input  wire battle_game_pkg::coord_t  i_cursor,
	input  wire                           i_placement_error,
	input  wire battle_io_pkg::shot_evt_t i_evt,
	input  wire                           i_evt_valid,
	input  wire [6:0]                     i_seg_player,
	input  wire [6:0]                     i_seg_pc,
	output int                            o_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N = `BOARD_N;

	// Cell codes of the model: 0 empty, 1 ship, 2 miss, 3 hit
	int          pb [N*N];     // Player board
	int          mb [N*N];     // Machine board
	int          p_left;
	int          m_left;
	int          target;       // Clamped ship count
	int          placed_p;
	int          placed_m;
	int          cur_r;
	int          cur_c;
	logic [15:0] lfsr;
	logic        exp_err;      // Error pulse due next cycle
	logic        pend;         // Player shot accepted, report not yet seen
	int          pend_r;
	int          pend_c;
	int          outstanding;  // Events not yet paid back by a credit
	battle_game_pkg::game_state_e exp_state;

	initial o_errors = 0;

	// Galois step, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] v);
		if (v[0])
			return (v >> 1) ^ 16'hB400;
		return v >> 1;
	endfunction

	// Digits 0 to 5, segments gfedcba
	function automatic logic [6:0] seg_code(input int n);
		case (n)
			0: return 7'b0111111;
			1: return 7'b0000110;
			2: return 7'b1011011;
			3: return 7'b1001111;
			4: return 7'b1100110;
			5: return 7'b1101101;
			default: return 7'b1000000;
		endcase
	endfunction

	function automatic int clamp_count(input int n);
		if (n < 1)
			return 1;
		if (n > `MAX_SHIPS)
			return `MAX_SHIPS;
		return n;
	endfunction

	// Candidate is on the grid and not yet fired at
	function automatic logic draw_usable(input logic [15:0] v);
		int r;
		int c;
		r = v[2:0];
		c = v[5:3];
		if (r >= N || c >= N)
			return 1'b0;
		return pb[r*N + c] < 2;
	endfunction

	task automatic report_value(input string name, input int exp_v, input int act_v);
		if (exp_v != act_v) begin
			o_errors++;
			$display("ERROR %s: expected %0h, actual %0h", name, exp_v, act_v);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < N*N; i++) begin
			pb[i] = 0;
			mb[i] = 0;
		end
		p_left      = 0;
		m_left      = 0;
		target      = 1;
		placed_p    = 0;
		placed_m    = 0;
		cur_r       = 0;
		cur_c       = 0;
		lfsr        = `LFSR_SEED;
		exp_err     = 1'b0;
		pend        = 1'b0;
		outstanding = 0;
		exp_state   = battle_game_pkg::DECIDE;
	endtask

	task automatic check_event();
		int r;
		int c;
		int guard;
		logic hit;
		logic over;
		logic by_pc;
		by_pc = !pend;  // No player shot waiting, so the machine fired
		if (by_pc && exp_state != battle_game_pkg::PC_TURN) begin
			o_errors++;
			$display("Shot report arrived while no shot was due");
		end
		if (!by_pc) begin
			r   = pend_r;
			c   = pend_c;
			hit = (mb[r*N + c] == 1);
			mb[r*N + c] = hit ? 3 : 2;
			if (hit)
				m_left--;
			over      = hit && (m_left == 0);
			exp_state = over ? battle_game_pkg::VICTORY : battle_game_pkg::PC_TURN;
			pend      = 1'b0;
		end else begin
			guard = 0;
			while (!draw_usable(lfsr) && guard < 70000) begin  // Skip used or off-grid cells
				lfsr = lfsr_next(lfsr);
				guard++;
			end
			r   = lfsr[2:0];
			c   = lfsr[5:3];
			hit = (pb[r*N + c] == 1);
			pb[r*N + c] = hit ? 3 : 2;
			if (hit)
				p_left--;
			over      = hit && (p_left == 0);
			exp_state = over ? battle_game_pkg::DEFEAT : battle_game_pkg::PLAYER_TURN;
			lfsr      = lfsr_next(lfsr);  // Shot itself is a draw
		end
		report_value("shooter", int'(by_pc), int'(i_evt.shooter));
		report_value(by_pc ? "pc_shot_coord" : "player_shot_coord",
			r*8 + c, int'(i_evt.coord.row)*8 + int'(i_evt.coord.col));
		report_value("shot_result", int'(hit), int'(i_evt.result));
		report_value("game_over", int'(over), int'(i_evt.game_over));
	endtask

	task automatic compare_outputs();
		report_value("state", int'(exp_state), int'(i_state));
		report_value("seg_player", seg_code(p_left), i_seg_player);
		report_value("seg_pc", seg_code(m_left), i_seg_pc);
		report_value("cursor", cur_r*8 + cur_c, int'(i_cursor.row)*8 + int'(i_cursor.col));
		report_value("placement_error", int'(exp_err), int'(i_placement_error));
		if (outstanding > `EVT_CREDITS) begin
			o_errors++;
			$display("Event sent while the channel had no credit left");
			outstanding = `EVT_CREDITS;
		end
	endtask

	task automatic move_cursor();
		if (i_btn.up) begin
			if (cur_r > 0) cur_r--;
		end else if (i_btn.down) begin
			if (cur_r < N-1) cur_r++;
		end else if (i_btn.left) begin
			if (cur_c > 0) cur_c--;
		end else if (i_btn.right) begin
			if (cur_c < N-1) cur_c++;
		end
	endtask

	task automatic apply_inputs();
		int idx;
		exp_err = 1'b0;
		idx     = cur_r*N + cur_c;
		case (exp_state)
			battle_game_pkg::DECIDE: begin
				if (i_btn.confirm_amount) begin
					target    = clamp_count(i_ship_count);
					exp_state = battle_game_pkg::PLACE;
				end
			end
			battle_game_pkg::PLACE: begin
				if (i_btn.confirm_place) begin
					if (pb[idx] == 0) begin
						pb[idx] = 1;
						p_left++;
						placed_p++;
						if (placed_p == target)
							exp_state = battle_game_pkg::SETUP;
					end else begin
						exp_err = 1'b1;  // Cell taken
					end
				end
				move_cursor();
			end
			battle_game_pkg::SETUP: begin
				idx = int'(lfsr[2:0])*N + int'(lfsr[5:3]);
				if (lfsr[2:0] < N && lfsr[5:3] < N && mb[idx] == 0) begin
					mb[idx] = 1;
					m_left++;
					placed_m++;
					if (placed_m == target)
						exp_state = battle_game_pkg::PLAYER_TURN;
				end
				lfsr = lfsr_next(lfsr);  // Every setup cycle draws
			end
			battle_game_pkg::PLAYER_TURN: begin
				if (i_btn.fire && !pend) begin
					if (mb[idx] >= 2) begin
						exp_err = 1'b1;  // Repeat shot
					end else begin
						pend   = 1'b1;
						pend_r = cur_r;
						pend_c = cur_c;
					end
				end
				move_cursor();
			end
			default: ;
		endcase
	endtask

	always @(posedge clk) begin
		if (!i_rst_n) begin
			reset_model();
		end else begin
			outstanding = outstanding + int'(i_evt_valid) - int'(i_evt_credit);
			if (i_evt_valid)
				check_event();  // Shot from the previous edge
			compare_outputs();
			apply_inputs();
		end
	end

endmodule

`default_nettype wire

// File: tb/battleship_tb.sv
`default_nettype none

`include "battle_macros.svh"

module battleship_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int A_RESET   = 0;
	localparam int A_AMOUNT  = 1;
	localparam int A_MOVE    = 2;  // Arg 0 up, 1 down, 2 left, 3 right
	localparam int A_PLACE   = 3;  // Arg is cell index
	localparam int A_FIRE    = 4;
	localparam int A_HOLD    = 5;  // Withhold credits
	localparam int A_RELEASE = 6;  // Arg is stall cycles checked
	localparam int A_END     = 7;
	localparam int MAX_ROWS  = 96;

	logic                         clk;
	logic                         rst_n;
	battle_io_pkg::buttons_t      btn;
	logic [2:0]                   ship_count;
	logic                         evt_credit;
	battle_game_pkg::game_state_e state;
	battle_game_pkg::coord_t      cursor;
	logic                         place_err;
	battle_io_pkg::shot_evt_t     evt;
	logic                         evt_valid;
	logic [6:0]                   seg_player;
	logic [6:0]                   seg_pc;

	int    row_act [MAX_ROWS];
	int    row_arg [MAX_ROWS];
	int    row_err [MAX_ROWS];
	string row_name [MAX_ROWS];
	int    n_rows;
	int    tb_errors;
	int    chk_errors;
	int    cycles;
	int    limit;
	int    outstanding;  // Events the receiver still owes credits for
	int    gap;
	logic  hold;

	tb_clock clk_i (.o_clk(clk));

	battleship_top dut_i (
		.clk(clk), .i_rst_n(rst_n), .i_btn(btn), .i_ship_count(ship_count),
		.i_evt_credit(evt_credit), .o_state(state), .o_cursor(cursor),
		.o_placement_error(place_err), .o_evt(evt), .o_evt_valid(evt_valid),
		.o_seg_player(seg_player), .o_seg_pc(seg_pc)
	);

	battleship_checker check_i (
		.clk(clk), .i_rst_n(rst_n), .i_btn(btn), .i_ship_count(ship_count),
		.i_evt_credit(evt_credit), .i_state(state), .i_cursor(cursor),
		.i_placement_error(place_err), .i_evt(evt), .i_evt_valid(evt_valid),
		.i_seg_player(seg_player), .i_seg_pc(seg_pc), .o_errors(chk_errors)
	);

	task automatic add_row(input int act, input int arg, input int err, input string name);
		row_act[n_rows]  = act;
		row_arg[n_rows]  = arg;
		row_err[n_rows]  = err;
		row_name[n_rows] = name;
		n_rows++;
	endtask

	task automatic build_table();
		n_rows = 0;
		add_row(A_AMOUNT, 7, 0, "amount_clamp_high");
		add_row(A_MOVE, 0, 0, "cursor_up_clamp");
		add_row(A_MOVE, 2, 0, "cursor_left_clamp");
		for (int i = 0; i < 6; i++)
			add_row(A_MOVE, 3, 0, $sformatf("cursor_right_%0d", i));  // Last one clamps
		for (int i = 0; i < 6; i++)
			add_row(A_MOVE, 1, 0, $sformatf("cursor_down_%0d", i));
		add_row(A_PLACE, 0, 0, "place_0");
		add_row(A_PLACE, 0, 1, "place_repeat");
		add_row(A_PLACE, 6, 0, "place_6");
		add_row(A_PLACE, 12, 0, "place_12");
		add_row(A_PLACE, 18, 0, "place_18");
		add_row(A_PLACE, 24, 0, "place_24");
		add_row(A_FIRE, 0, 0, "fire_0");
		add_row(A_FIRE, 0, 1, "fire_repeat");
		add_row(A_HOLD, 0, 0, "credit_hold");
		for (int i = 1; i < 4; i++)
			add_row(A_FIRE, i, 0, $sformatf("fire_%0d", i));  // Third one stalls
		add_row(A_RELEASE, 20, 0, "credit_release");
		for (int i = 4; i < 25; i++)
			add_row(A_FIRE, i, 0, $sformatf("fire_%0d", i));
		add_row(A_END, 0, 0, "end_state_a");
		add_row(A_RESET, 0, 0, "reset_game");
		add_row(A_AMOUNT, 0, 0, "amount_clamp_low");
		add_row(A_PLACE, 7, 0, "place_single");
		for (int i = 0; i < 25; i++)
			add_row(A_FIRE, i, 0, $sformatf("b_fire_%0d", i));
		add_row(A_END, 0, 0, "end_state_b");
	endtask

	function automatic logic game_ended();
		return state == battle_game_pkg::VICTORY || state == battle_game_pkg::DEFEAT;
	endfunction

	task automatic do_reset();
		@(negedge clk);
		rst_n = 1'b0;
		btn   = '0;
		hold  = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// One-cycle button pulse, starting on a falling edge
	task automatic pulse(input battle_io_pkg::buttons_t b);
		btn = b;
		@(negedge clk);
		btn = '0;
	endtask

	task automatic goto_cell(input int idx);
		battle_io_pkg::buttons_t b;
		int r;
		int c;
		r = idx / `BOARD_N;
		c = idx % `BOARD_N;
		while (int'(cursor.row) != r || int'(cursor.col) != c) begin
			b = '0;
			if (int'(cursor.row) > r)
				b.up = 1'b1;
			else if (int'(cursor.row) < r)
				b.down = 1'b1;
			else if (int'(cursor.col) > c)
				b.left = 1'b1;
			else
				b.right = 1'b1;
			pulse(b);
		end
	endtask

	task automatic check_flag(input int row, input int seen);
		if (seen != row_err[row]) begin
			tb_errors++;
			$display("ERROR %s: expected %0d, actual %0d", row_name[row], row_err[row], seen);
		end
	endtask

	task automatic run_row(input int row);
		battle_io_pkg::buttons_t b;
		int seen;
		b    = '0;
		seen = 0;
		case (row_act[row])
			A_RESET: do_reset();
			A_AMOUNT: begin
				ship_count       = 3'(row_arg[row]);
				b.confirm_amount = 1'b1;
				pulse(b);
				while (state != battle_game_pkg::PLACE)
					@(negedge clk);
			end
			A_MOVE: begin
				b.up    = (row_arg[row] == 0);
				b.down  = (row_arg[row] == 1);
				b.left  = (row_arg[row] == 2);
				b.right = (row_arg[row] == 3);
				pulse(b);
			end
			A_PLACE: begin
				goto_cell(row_arg[row]);
				b.confirm_place = 1'b1;
				pulse(b);
				seen = int'(place_err);  // Error pulse follows the press edge
				repeat (2) begin
					@(negedge clk);
					seen = seen | int'(place_err);
				end
				check_flag(row, seen);
			end
			A_FIRE: begin
				while (state != battle_game_pkg::PLAYER_TURN && !game_ended())
					@(negedge clk);
				if (!game_ended()) begin
					goto_cell(row_arg[row]);
					b.fire = 1'b1;
					pulse(b);
					seen = int'(place_err);
					repeat (3) begin
						@(negedge clk);
						seen = seen | int'(place_err);
					end
					check_flag(row, seen);
					// Shot without credit stays pending, nothing to wait for
					if (!row_err[row] && !hold)
						while (state == battle_game_pkg::PLAYER_TURN)
							@(negedge clk);
				end
			end
			A_HOLD: begin
				while (outstanding != 0)
					@(negedge clk);
				hold = 1'b1;
			end
			A_RELEASE: begin
				if (outstanding != `EVT_CREDITS) begin
					tb_errors++;
					$display("Credits were not used up before the stall check (%0d owed)",
						outstanding);
				end
				repeat (row_arg[row]) begin
					@(negedge clk);
					if (evt_valid || state != battle_game_pkg::PLAYER_TURN) begin
						tb_errors++;
						$display("Event or turn change while credits were withheld");
					end
				end
				hold = 1'b0;
				while (state == battle_game_pkg::PLAYER_TURN)
					@(negedge clk);
			end
			A_END: begin
				repeat (10) @(negedge clk);
				if (!game_ended()) begin
					tb_errors++;
					$display("Game did not reach VICTORY or DEFEAT in %s", row_name[row]);
				end
			end
			default: ;
		endcase
	endtask

	// Receiver side, pays credits back after random gaps
	always @(posedge clk) begin
		if (!rst_n)
			outstanding = 0;
		else
			outstanding = outstanding + int'(evt_valid) - int'(evt_credit);
	end

	always @(negedge clk) begin
		evt_credit = 1'b0;
		if (rst_n && !hold && outstanding > 0) begin
			if (gap == 0) begin
				evt_credit = 1'b1;
				gap        = $urandom % 4;
			end else begin
				gap--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, the run did not finish", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		rst_n      = 1'b0;
		btn        = '0;
		ship_count = 3'd0;
		evt_credit = 1'b0;
		hold       = 1'b0;
		tb_errors  = 0;
		cycles     = 0;
		limit      = 0;
		outstanding = 0;
		gap        = $urandom(32'h266f_ff23) % 4;  // Only seeding call
		build_table();
		limit = n_rows * (`PC_THINK_CYCLES + 64);
		do_reset();
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		repeat (2) @(negedge clk);
		$display("Checks done: %0d testbench errors, %0d checker errors", tb_errors, chk_errors);
		if (tb_errors == 0 && chk_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/battle_game_pkg.sv
src/battle_io_pkg.sv
src/game_fsm.sv
src/turn_timer.sv
src/cursor_ctrl.sv
src/coord_lfsr.sv
src/ship_board.sv
src/event_link.sv
src/battleship_top.sv
tb/tb_clock.sv
tb/battleship_checker.sv
tb/battleship_tb.sv
